// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fp_accel
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
rtl/fp_pkg.sv
rtl/fp_regs_pkg.sv
rtl/fp_mult.sv
rtl/fp_add.sv
rtl/fp_axil_regs.sv
rtl/fp_accel_top.sv
sim/clk_gen.sv
sim/tb_fp_accel.sv

// ==== rtl/fp_accel_top.sv ====
`timescale 1ns/10ps

module fp_accel_top import fp_pkg::*, fp_regs_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready
);

    fp32_u     op_a, op_b;
    fp32_u     mul_result, add_result;
    fp_flags_t mul_flags, add_flags;

    fp_axil_regs fp_axil_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .op_a       (op_a),
        .op_b       (op_b),
        .mul_result (mul_result),
        .add_result (add_result),
        .mul_flags  (mul_flags),
        .add_flags  (add_flags)
    );

    // both units see the same operands and ctrl picks which one is kept
    fp_mult fp_mult_inst (
        .a      (op_a),
        .b      (op_b),
        .result (mul_result),
        .flags  (mul_flags)
    );

    fp_add fp_add_inst (
        .a      (op_a),
        .b      (op_b),
        .result (add_result),
        .flags  (add_flags)
    );

endmodule

// ==== rtl/fp_add.sv ====
`timescale 1ns/10ps

module fp_add import fp_pkg::*; (
    input  fp32_u     a,
    input  fp32_u     b,
    output fp32_u     result,
    output fp_flags_t flags
);

    logic              a_zero, b_zero;
    logic              a_inf, b_inf;
    logic              a_nan, b_nan;
    logic              a_big;
    logic              eff_sub;
    fp32_u             op_big, op_small;
    logic [EXP_W-1:0]  exp_diff;
    logic [MANT_W:0]   mant_big, mant_small;
    logic [MANT_W+1:0] mant_sum;   // one extra bit for the carry
    logic [4:0]        lz;
    logic [MANT_W-1:0] mant_norm;
    logic signed [9:0] exp_norm;

    assign a_zero = (a.f.exp == '0);   // subnormal flushed
    assign b_zero = (b.f.exp == '0);
    assign a_inf  = (a.f.exp == EXP_W'(EXP_MAX)) && (a.f.mant == '0);
    assign b_inf  = (b.f.exp == EXP_W'(EXP_MAX)) && (b.f.mant == '0);
    assign a_nan  = (a.f.exp == EXP_W'(EXP_MAX)) && (a.f.mant != '0);
    assign b_nan  = (b.f.exp == EXP_W'(EXP_MAX)) && (b.f.mant != '0);

    // exponent and mantissa compare as one integer for the magnitude order
    assign a_big    = (a.bits[30:0] >= b.bits[30:0]);
    assign op_big   = a_big ? a : b;
    assign op_small = a_big ? b : a;
    assign eff_sub  = a.f.sign ^ b.f.sign;

    // bits shifted out in the alignment are lost
    assign exp_diff   = op_big.f.exp - op_small.f.exp;
    assign mant_big   = {1'b1, op_big.f.mant};
    assign mant_small = {1'b1, op_small.f.mant} >> exp_diff;

    assign mant_sum = eff_sub ? {1'b0, mant_big} - {1'b0, mant_small}
                              : {1'b0, mant_big} + {1'b0, mant_small};

    // leading one search where the highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i <= MANT_W; i++) begin
            if (mant_sum[i]) begin
                lz = 5'(MANT_W - i);
            end
        end
    end

    always_comb begin
        if (mant_sum[MANT_W+1]) begin
            mant_norm = mant_sum[MANT_W:1];
            exp_norm  = $signed({2'b00, op_big.f.exp}) + 10'sd1;
        end else begin
            mant_norm = mant_sum[MANT_W-1:0] << lz;   // hidden one drops out
            exp_norm  = $signed({2'b00, op_big.f.exp}) - $signed({5'b00000, lz});
        end
    end

    always_comb begin
        result = '0;
        flags  = '0;

        if (a_nan || b_nan || (a_inf && b_inf && eff_sub)) begin
            result.bits   = QNAN_WORD;
            flags.invalid = 1'b1;
        end else if (a_inf) begin
            result = a;
        end else if (b_inf) begin
            result = b;
        end else if (a_zero && b_zero) begin
            result.f.sign = a.f.sign & b.f.sign;   // -0 only if both negative
        end else if (a_zero) begin
            result = b;
        end else if (b_zero) begin
            result = a;
        end else if (mant_sum == '0) begin
            result = '0;                            // exact cancellation
        end else if (exp_norm > EXP_MAX - 1) begin
            result.f.sign  = op_big.f.sign;
            result.f.exp   = EXP_W'(EXP_MAX);
            flags.overflow = 1'b1;
        end else if (exp_norm < 1) begin
            result.f.sign   = op_big.f.sign;
            flags.underflow = 1'b1;
        end else begin
            result.f.sign = op_big.f.sign;
            result.f.exp  = exp_norm[EXP_W-1:0];
            result.f.mant = mant_norm;
        end
    end

endmodule

// ==== rtl/fp_axil_regs.sv ====
`timescale 1ns/10ps

module fp_axil_regs import fp_pkg::*, fp_regs_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,    // ignored since every write is a full word
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    output fp32_u             op_a,
    output fp32_u             op_b,
    input  fp32_u             mul_result,
    input  fp32_u             add_result,
    input  fp_flags_t         mul_flags,
    input  fp_flags_t         add_flags
);

    logic        bus_en;       // high from the first cycle after reset
    logic        wr_hs, rd_hs;
    logic        start;
    logic        op_sel;       // ctrl register with 1 selecting add
    fp32_u       result_q;
    fp_flags_t   flags_q;
    fp_flags_t   unit_flags;
    fp32_u       unit_result;
    logic        done_q;
    logic        status_rd;
    logic [31:0] status_word;
    logic [31:0] rd_word;
    logic        rd_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_en <= 1'b0;
        end else begin
            bus_en <= 1'b1;
        end
    end

    // address and data taken together and blocked while a response is held
    assign wr_hs   = bus_en & awvalid & wvalid & ~bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;

    assign arready = bus_en & ~rvalid;
    assign rd_hs   = arvalid & arready;

    assign start     = wr_hs && (awaddr == REG_CTRL);
    assign status_rd = rd_hs && (araddr == REG_STATUS);

    // operands are already stable when ctrl is written, so the selected
    // unit output is valid at the handshake and lands together with bvalid
    assign unit_result = wdata[CTRL_OP_BIT] ? add_result : mul_result;
    assign unit_flags  = wdata[CTRL_OP_BIT] ? add_flags  : mul_flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_a   <= '0;
            op_b   <= '0;
            op_sel <= 1'b0;
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
                case (awaddr)
                    REG_OP_A: op_a.bits <= wdata;
                    REG_OP_B: op_b.bits <= wdata;
                    REG_CTRL: op_sel    <= wdata[CTRL_OP_BIT];
                    default:  bresp     <= RESP_SLVERR;   // result, status, unmapped
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // a new capture wins over the read-clear of the sticky status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
            flags_q  <= '0;
            done_q   <= 1'b0;
        end else begin
            if (start) begin
                result_q <= unit_result;
                flags_q  <= (status_rd ? fp_flags_t'('0) : flags_q) | unit_flags;
                done_q   <= 1'b1;
            end else if (status_rd) begin
                flags_q <= '0;
                done_q  <= 1'b0;
            end
        end
    end

    always_comb begin
        status_word                                          = '0;
        status_word[STATUS_DONE_BIT]                         = done_q;
        status_word[STATUS_FLAGS_LSB +: $bits(fp_flags_t)]   = flags_q;
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (araddr)
            REG_OP_A:   rd_word = op_a.bits;
            REG_OP_B:   rd_word = op_b.bits;
            REG_CTRL:   rd_word[CTRL_OP_BIT] = op_sel;
            REG_RESULT: rd_word = result_q.bits;
            REG_STATUS: rd_word = status_word;
            default:    rd_err  = 1'b1;   // unmapped reads return zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end else begin
            if (rd_hs) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;   // data held until accepted
            end
        end
    end

endmodule

// ==== rtl/fp_mult.sv ====
`timescale 1ns/10ps

module fp_mult import fp_pkg::*; (
    input  fp32_u     a,
    input  fp32_u     b,
    output fp32_u     result,
    output fp_flags_t flags
);

    logic                a_zero, b_zero;
    logic                a_inf, b_inf;
    logic                a_nan, b_nan;
    logic                sign_r;
    logic [MANT_W:0]     mant_a, mant_b;
    logic [2*MANT_W+1:0] prod;          // 24 x 24 = 48 bits
    logic signed [9:0]   exp_sum;
    logic signed [9:0]   exp_norm;
    logic [MANT_W-1:0]   mant_norm;

    // subnormals count as zero in the operand classes
    assign a_zero = (a.f.exp == '0);
    assign b_zero = (b.f.exp == '0);
    assign a_inf  = (a.f.exp == EXP_W'(EXP_MAX)) && (a.f.mant == '0);
    assign b_inf  = (b.f.exp == EXP_W'(EXP_MAX)) && (b.f.mant == '0);
    assign a_nan  = (a.f.exp == EXP_W'(EXP_MAX)) && (a.f.mant != '0);
    assign b_nan  = (b.f.exp == EXP_W'(EXP_MAX)) && (b.f.mant != '0);

    assign sign_r = a.f.sign ^ b.f.sign;

    // hidden one restored
    assign mant_a = {1'b1, a.f.mant};
    assign mant_b = {1'b1, b.f.mant};
    assign prod   = mant_a * mant_b;

    // 10 bits signed keeps both overflow and underflow visible
    assign exp_sum = $signed({2'b00, a.f.exp}) + $signed({2'b00, b.f.exp})
                   - 10'(EXP_BIAS);

    // product of two values in [1,2) lies in [1,4)
    always_comb begin
        if (prod[2*MANT_W+1]) begin
            mant_norm = prod[2*MANT_W:MANT_W+1];   // shift right by one
            exp_norm  = exp_sum + 10'sd1;
        end else begin
            mant_norm = prod[2*MANT_W-1:MANT_W];
            exp_norm  = exp_sum;
        end
    end

    always_comb begin
        result = '0;
        flags  = '0;

        if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
            result.bits   = QNAN_WORD;
            flags.invalid = 1'b1;
        end else if (a_zero || b_zero) begin
            result.f.sign = sign_r;                 // signed zero
        end else if (a_inf || b_inf) begin
            result.f.sign = sign_r;
            result.f.exp  = EXP_W'(EXP_MAX);
        end else if (exp_norm > EXP_MAX - 1) begin
            result.f.sign  = sign_r;
            result.f.exp   = EXP_W'(EXP_MAX);
            flags.overflow = 1'b1;
        end else if (exp_norm < 1) begin
            // flushed since there is no subnormal output
            result.f.sign   = sign_r;
            flags.underflow = 1'b1;
        end else begin
            result.f.sign = sign_r;
            result.f.exp  = exp_norm[EXP_W-1:0];
            result.f.mant = mant_norm;              // truncated
        end
    end

endmodule

// ==== rtl/fp_pkg.sv ====
package fp_pkg;

    // binary32 field widths
    localparam int EXP_W    = 8;
    localparam int MANT_W   = 23;

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;   // all-ones exponent for inf and nan

    // canonical quiet nan
    localparam logic [31:0] QNAN_WORD = 32'h7FC0_0000;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] mant;
    } fp32_fields_t;

    // one word seen raw on the bus and as fields by the arithmetic
    typedef union packed {
        logic [31:0]  bits;
        fp32_fields_t f;
    } fp32_u;

    // exception flags with invalid as msb
    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
    } fp_flags_t;

endpackage

// ==== rtl/fp_regs_pkg.sv ====
package fp_regs_pkg;

    localparam int ADDR_W = 5;

    // register map in byte addresses
    localparam logic [ADDR_W-1:0] REG_OP_A   = 5'h00;
    localparam logic [ADDR_W-1:0] REG_OP_B   = 5'h04;
    localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08;
    localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C;
    localparam logic [ADDR_W-1:0] REG_STATUS = 5'h10;

    localparam int CTRL_OP_BIT      = 0;   // 0 = multiply, 1 = add
    localparam int STATUS_DONE_BIT  = 0;
    localparam int STATUS_FLAGS_LSB = 1;   // invalid, overflow, underflow above done

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== sim/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #10 rst_n = 1'b1;         // released off the edge
    end

endmodule

// ==== sim/tb_fp_accel.sv ====
`timescale 1ns/10ps

module tb_fp_accel import fp_pkg::*, fp_regs_pkg::*; ();

    localparam int        DRV     = 10;   // drive delay after the rising edge
    localparam int        TIMEOUT = 50;   // cycles per wait
    localparam logic      OP_MUL  = 1'b0;
    localparam logic      OP_ADD  = 1'b1;
    localparam fp_flags_t F_NONE  = 3'b000;
    localparam fp_flags_t F_INV   = 3'b100;
    localparam fp_flags_t F_OVF   = 3'b010;
    localparam fp_flags_t F_UNF   = 3'b001;

    typedef struct packed {
        fp32_u      a;
        fp32_u      b;
        logic       op;
        fp32_u      res;
        fp_flags_t  flags;
        logic [1:0] resp;
        logic       rd_status;   // low keeps the sticky flags for the next row
    } vec_t;

    logic              clk, rst_n;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;
    logic              arvalid, arready, rvalid, rready;
    logic [31:0]       wdata, rdata;
    logic [3:0]        wstrb;
    logic [1:0]        bresp, rresp;

    vec_t        vecs[$];
    integer      seed = 97213;
    int          word_errs, flag_errs, resp_errs, other_errs;
    logic [31:0] data, rnd_a, rnd_b, ctrl_word;
    logic [1:0]  resp;
    int          n;

    clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

    fp_accel_top fp_accel_top_inst (
        .clk(clk), .rst_n(rst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    task automatic abort_timeout(input string what);
        $display("timeout waiting for %s", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic check_word(input string name, input fp32_u got, input fp32_u want);
        if (got.bits !== want.bits) begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got.bits, want.bits);
            word_errs++;
        end
    endtask

    task automatic check_flags(input string name, input fp_flags_t got, input fp_flags_t want);
        if (got !== want) begin
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, want);
            flag_errs++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, want);
            resp_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, want);
            other_errs++;
        end
    endtask

    // bready stays low for hold cycles once bvalid is seen
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] wd,
                             input int hold, output logic [1:0] br);
        int cnt;
        @(posedge clk);
        #DRV;
        awaddr  = addr;
        wdata   = wd;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cnt     = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            cnt++;
            if (cnt > TIMEOUT) abort_timeout("the write address and data handshake");
            @(negedge clk);
        end
        @(posedge clk);
        #DRV;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cnt     = 0;
        @(negedge clk);
        while (!bvalid) begin
            cnt++;
            if (cnt > TIMEOUT) abort_timeout("bvalid");
            @(negedge clk);
        end
        br = bresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (!bvalid || bresp !== br) begin
                $display("write response dropped or changed while bready was low");
                other_errs++;
            end
        end
        @(posedge clk);
        #DRV bready = 1'b1;
        @(posedge clk);
        #DRV bready = 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, input int hold,
                            output logic [31:0] rd, output logic [1:0] rr);
        int cnt;
        @(posedge clk);
        #DRV;
        araddr  = addr;
        arvalid = 1'b1;
        cnt     = 0;
        @(negedge clk);
        while (!arready) begin
            cnt++;
            if (cnt > TIMEOUT) abort_timeout("arready");
            @(negedge clk);
        end
        @(posedge clk);
        #DRV arvalid = 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!rvalid) begin
            cnt++;
            if (cnt > TIMEOUT) abort_timeout("rvalid");
            @(negedge clk);
        end
        rd = rdata;
        rr = rresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (!rvalid || rdata !== rd || rresp !== rr) begin
                $display("read data dropped or changed while rready was low");
                other_errs++;
            end
        end
        @(posedge clk);
        #DRV rready = 1'b1;
        @(posedge clk);
        #DRV rready = 1'b0;
    endtask

    task automatic add_vec(input logic [31:0] a, input logic [31:0] b, input logic op,
                           input logic [31:0] res, input fp_flags_t fl, input logic rs);
        vec_t v;
        v.a         = a;
        v.b         = b;
        v.op        = op;
        v.res       = res;
        v.flags     = fl;
        v.resp      = RESP_OKAY;
        v.rd_status = rs;
        vecs.push_back(v);
    endtask

    task automatic load_vectors();
        add_vec(32'h3FC00000, 32'h40000000, OP_MUL, 32'h40400000, F_NONE, 1'b1); // 1.5 * 2
        add_vec(32'hC0400000, 32'h3F000000, OP_MUL, 32'hBFC00000, F_NONE, 1'b1); // -3 * 0.5
        add_vec(32'h3F800000, 32'hBF800000, OP_ADD, 32'h00000000, F_NONE, 1'b1); // cancels
        add_vec(32'h3F800000, 32'h3E800000, OP_ADD, 32'h3FA00000, F_NONE, 1'b1); // 1 + 0.25
        add_vec(32'h3F800000, 32'hBF400000, OP_ADD, 32'h3E800000, F_NONE, 1'b1); // 1 - 0.75
        add_vec(32'h7F800001, 32'h3F800000, OP_MUL, QNAN_WORD,    F_INV,  1'b1);
        add_vec(32'h7FC00000, 32'h3F800000, OP_ADD, QNAN_WORD,    F_INV,  1'b1);
        add_vec(32'h7F800000, 32'h00000000, OP_MUL, QNAN_WORD,    F_INV,  1'b1); // inf * 0
        add_vec(32'h7F800000, 32'hFF800000, OP_ADD, QNAN_WORD,    F_INV,  1'b1); // inf - inf
        add_vec(32'h00000001, 32'h40000000, OP_MUL, 32'h00000000, F_NONE, 1'b1); // subnormal
        add_vec(32'h80000005, 32'h3F800000, OP_ADD, 32'h3F800000, F_NONE, 1'b1);
        add_vec(32'h7F800000, 32'hC0000000, OP_MUL, 32'hFF800000, F_NONE, 1'b1); // inf * -2
        add_vec(32'h7F000000, 32'h40000000, OP_MUL, 32'h7F800000, F_OVF,  1'b0);
        add_vec(32'h3FC00000, 32'h40000000, OP_MUL, 32'h40400000, F_OVF,  1'b1); // still sticky
        add_vec(32'h80800000, 32'h3F000000, OP_MUL, 32'h80000000, F_UNF,  1'b0);
        add_vec(32'h3F800000, 32'h3F800000, OP_ADD, 32'h40000000, F_UNF,  1'b1);
        add_vec(32'h7F7FFFFF, 32'h7F7FFFFF, OP_ADD, 32'h7F800000, F_OVF,  1'b1);
        add_vec(32'h40400000, 32'h3F800000, OP_ADD, 32'h40800000, F_NONE, 1'b1); // cleared
    endtask

    initial begin
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = 4'hF;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        word_errs  = 0;
        flag_errs  = 0;
        resp_errs  = 0;
        other_errs = 0;
        load_vectors();

        n = 0;
        while (rst_n !== 1'b1) begin
            n++;
            if (n > TIMEOUT) abort_timeout("reset release");
            @(posedge clk);
        end

        foreach (vecs[i]) begin
            ctrl_word              = '0;
            ctrl_word[CTRL_OP_BIT] = vecs[i].op;
            write_reg(REG_OP_A, vecs[i].a.bits, 0, resp);
            write_reg(REG_OP_B, vecs[i].b.bits, 0, resp);
            write_reg(REG_CTRL, ctrl_word, 0, resp);
            check_resp($sformatf("bresp row %0d", i), resp, vecs[i].resp);
            read_reg(REG_RESULT, 0, data, resp);
            check_word($sformatf("result row %0d", i), data, vecs[i].res);
            if (vecs[i].rd_status) begin
                read_reg(REG_STATUS, 0, data, resp);
                check_bit($sformatf("done row %0d", i), data[STATUS_DONE_BIT], 1'b1);
                check_flags($sformatf("flags row %0d", i),
                            data[STATUS_FLAGS_LSB +: $bits(fp_flags_t)], vecs[i].flags);
            end
        end

        // second status read sees everything cleared
        read_reg(REG_STATUS, 0, data, resp);
        check_bit("done after clear", data[STATUS_DONE_BIT], 1'b0);
        check_flags("flags after clear", data[STATUS_FLAGS_LSB +: $bits(fp_flags_t)], F_NONE);

        for (int k = 0; k < 4; k++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            write_reg(REG_OP_A, rnd_a, 0, resp);
            write_reg(REG_OP_B, rnd_b, 0, resp);
            read_reg(REG_OP_A, 0, data, resp);
            check_word("op_a readback", data, rnd_a);
            read_reg(REG_OP_B, 0, data, resp);
            check_word("op_b readback", data, rnd_b);
        end

        // result still holds the last row of the table
        write_reg(REG_RESULT, 32'hDEADBEEF, 0, resp);
        check_resp("bresp result write", resp, RESP_SLVERR);
        read_reg(REG_RESULT, 0, data, resp);
        check_word("result after bad write", data, vecs[vecs.size()-1].res);
        write_reg(REG_STATUS, 32'h0000000F, 0, resp);
        check_resp("bresp status write", resp, RESP_SLVERR);
        write_reg(5'h14, 32'h12345678, 0, resp);
        check_resp("bresp unmapped write", resp, RESP_SLVERR);
        read_reg(5'h14, 0, data, resp);
        check_resp("rresp unmapped read", resp, RESP_SLVERR);
        check_word("rdata unmapped read", data, 32'h0);

        // back-pressure on both response channels
        write_reg(REG_OP_A, 32'h40490FDB, 6, resp);
        check_resp("bresp held write", resp, RESP_OKAY);
        read_reg(REG_OP_A, 6, data, resp);
        check_resp("rresp held read", resp, RESP_OKAY);
        check_word("rdata held read", data, 32'h40490FDB);

        $display("errors: word %0d, flags %0d, resp %0d, other %0d",
                 word_errs, flag_errs, resp_errs, other_errs);
        if (word_errs + flag_errs + resp_errs + other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
